//--- files.f
hw/scr1_mem_pkg.sv
hw/scr1_dmem_dispatch.sv
hw/scr1_timer.sv
hw/scr1_ext_port.sv
hw/scr1_resp_merge.sv
hw/scr1_mem_cluster.sv
testbench/tb_mem_cluster.sv

//--- hw/scr1_dmem_dispatch.sv
// Data memory request dispatch
// Mask/pattern decode of the core address toward the timer or the external port

`timescale 1ns/1ps

module scr1_dmem_dispatch
    import scr1_mem_pkg::*;
#(
    parameter logic [SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter logic [SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000
) (
    input  logic        clk,

    // Core side
    input  logic        core_req_valid_i,
    input  dmem_req_t   core_req_i,
    output logic        core_req_ready_o,

    // Timer target
    output logic        timer_req_valid_o,
    output dmem_req_t   timer_req_o,
    input  logic        timer_req_ready_i,

    // External port target
    output logic        ext_req_valid_o,
    output dmem_req_t   ext_req_o,
    input  logic        ext_req_ready_i,

    // Order queue in the merge stage
    output logic        order_push_o,
    output dmem_tgt_e   order_tgt_o,
    input  logic        order_full_i
);

    logic       hit_timer;
    logic       tgt_ready;
    dmem_tgt_e  tgt;

    // Address decode
    assign hit_timer = ((core_req_i.addr & TIMER_ADDR_MASK) == TIMER_ADDR_PATTERN);
    assign tgt       = hit_timer ? TGT_TIMER : TGT_EXT;
    assign tgt_ready = hit_timer ? timer_req_ready_i : ext_req_ready_i;

    // A request only leaves while its tag has a slot
    assign core_req_ready_o  = tgt_ready & ~order_full_i;
    assign timer_req_valid_o = core_req_valid_i & hit_timer & ~order_full_i;
    assign ext_req_valid_o   = core_req_valid_i & ~hit_timer & ~order_full_i;

    assign timer_req_o = core_req_i;    // Same payload to both, valid picks one
    assign ext_req_o   = core_req_i;

    assign order_push_o = core_req_valid_i & core_req_ready_o;
    assign order_tgt_o  = tgt;

endmodule : scr1_dmem_dispatch

//--- hw/scr1_ext_port.sv
// External bus port
// One-entry request register toward the bus, one-entry response register back

`timescale 1ns/1ps

module scr1_ext_port
    import scr1_mem_pkg::*;
(
    input  logic        clk,
    input  logic        core_rst_n_local,

    // From dispatch
    input  logic        req_valid_i,
    input  dmem_req_t   req_i,
    output logic        req_ready_o,

    // External bus
    output logic        ext_req_valid_o,
    output dmem_req_t   ext_req_o,
    input  logic        ext_req_ready_i,
    input  logic        ext_resp_valid_i,
    input  dmem_resp_t  ext_resp_i,
    output logic        ext_resp_ready_o,

    // Toward merge
    output logic        resp_valid_o,
    output dmem_resp_t  resp_o,
    input  logic        resp_ready_i
);

    logic req_load;
    logic resp_load;

    // --------------------
    // Request stage
    // --------------------
    assign req_ready_o = ~ext_req_valid_o | ext_req_ready_i;
    assign req_load    = req_valid_i & req_ready_o;

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) ext_req_valid_o <= 1'b0;
        else if (req_ready_o)  ext_req_valid_o <= req_valid_i;
    end

    always_ff @(posedge clk) begin
        if (req_load) ext_req_o <= req_i;
    end

    // --------------------
    // Response stage
    // --------------------
    assign ext_resp_ready_o = ~resp_valid_o | resp_ready_i;
    assign resp_load        = ext_resp_valid_i & ext_resp_ready_o;

    always_ff @(posedge clk) begin
        if (~core_rst_n_local)     resp_valid_o <= 1'b0;
        else if (ext_resp_ready_o) resp_valid_o <= ext_resp_valid_i;
    end

    always_ff @(posedge clk) begin
        if (resp_load) resp_o <= ext_resp_i;
    end

endmodule : scr1_ext_port

//--- hw/scr1_mem_cluster.sv
// Data memory cluster top
// Dispatch, machine timer, external port and in-order response merge

`timescale 1ns/1ps

module scr1_mem_cluster
    import scr1_mem_pkg::*;
#(
    parameter logic [SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0,
    parameter logic [SCR1_DMEM_AWIDTH-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000,
    parameter int                          ORDER_DEPTH        = 4
) (
    input  logic        clk,
    input  logic        core_rst_n_local,

    // Core
    input  logic        core_req_valid_i,
    input  dmem_req_t   core_req_i,
    output logic        core_req_ready_o,
    output logic        core_resp_valid_o,
    output dmem_resp_t  core_resp_o,
    input  logic        core_resp_ready_i,

    // External bus
    output logic        ext_req_valid_o,
    output dmem_req_t   ext_req_o,
    input  logic        ext_req_ready_i,
    input  logic        ext_resp_valid_i,
    input  dmem_resp_t  ext_resp_i,
    output logic        ext_resp_ready_o,

    output logic        timer_irq_o
);

    logic        timer_req_valid;
    dmem_req_t   timer_req;
    logic        timer_req_ready;
    logic        timer_resp_valid;
    dmem_resp_t  timer_resp;
    logic        timer_resp_ready;

    logic        port_req_valid;
    dmem_req_t   port_req;
    logic        port_req_ready;
    logic        port_resp_valid;
    dmem_resp_t  port_resp;
    logic        port_resp_ready;

    logic        order_push;
    dmem_tgt_e   order_tgt;
    logic        order_full;

    scr1_dmem_dispatch #(
        .TIMER_ADDR_MASK    (TIMER_ADDR_MASK),
        .TIMER_ADDR_PATTERN (TIMER_ADDR_PATTERN)
    ) i_dispatch (
        .clk                (clk),
        .core_req_valid_i   (core_req_valid_i),
        .core_req_i         (core_req_i),
        .core_req_ready_o   (core_req_ready_o),
        .timer_req_valid_o  (timer_req_valid),
        .timer_req_o        (timer_req),
        .timer_req_ready_i  (timer_req_ready),
        .ext_req_valid_o    (port_req_valid),
        .ext_req_o          (port_req),
        .ext_req_ready_i    (port_req_ready),
        .order_push_o       (order_push),
        .order_tgt_o        (order_tgt),
        .order_full_i       (order_full)
    );

    scr1_timer i_timer (
        .clk                (clk),
        .core_rst_n_local   (core_rst_n_local),
        .req_valid_i        (timer_req_valid),
        .req_i              (timer_req),
        .req_ready_o        (timer_req_ready),
        .resp_valid_o       (timer_resp_valid),
        .resp_o             (timer_resp),
        .resp_ready_i       (timer_resp_ready),
        .timer_irq_o        (timer_irq_o)
    );

    scr1_ext_port i_ext_port (
        .clk                (clk),
        .core_rst_n_local   (core_rst_n_local),
        .req_valid_i        (port_req_valid),
        .req_i              (port_req),
        .req_ready_o        (port_req_ready),
        .ext_req_valid_o    (ext_req_valid_o),
        .ext_req_o          (ext_req_o),
        .ext_req_ready_i    (ext_req_ready_i),
        .ext_resp_valid_i   (ext_resp_valid_i),
        .ext_resp_i         (ext_resp_i),
        .ext_resp_ready_o   (ext_resp_ready_o),
        .resp_valid_o       (port_resp_valid),
        .resp_o             (port_resp),
        .resp_ready_i       (port_resp_ready)
    );

    scr1_resp_merge #(
        .ORDER_DEPTH        (ORDER_DEPTH)
    ) i_merge (
        .clk                (clk),
        .core_rst_n_local   (core_rst_n_local),
        .order_push_i       (order_push),
        .order_tgt_i        (order_tgt),
        .order_full_o       (order_full),
        .timer_resp_valid_i (timer_resp_valid),
        .timer_resp_i       (timer_resp),
        .timer_resp_ready_o (timer_resp_ready),
        .ext_resp_valid_i   (port_resp_valid),
        .ext_resp_i         (port_resp),
        .ext_resp_ready_o   (port_resp_ready),
        .core_resp_valid_o  (core_resp_valid_o),
        .core_resp_o        (core_resp_o),
        .core_resp_ready_i  (core_resp_ready_i)
    );

endmodule : scr1_mem_cluster

//--- hw/scr1_mem_pkg.sv
// Data memory cluster shared definitions
// Address and data widths, command and width encodings
// Request, response and routing tag types, timer register offsets

package scr1_mem_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int SCR1_DMEM_AWIDTH = 32;
    localparam int SCR1_DMEM_DWIDTH = 32;

    // --------------------
    // Encodings
    // --------------------
    typedef enum logic {
        SCR1_MEM_CMD_RD = 1'b0,
        SCR1_MEM_CMD_WR = 1'b1
    } type_scr1_mem_cmd_e;

    typedef enum logic [1:0] {
        SCR1_MEM_WIDTH_BYTE  = 2'b00,
        SCR1_MEM_WIDTH_HWORD = 2'b01,
        SCR1_MEM_WIDTH_WORD  = 2'b10
    } type_scr1_mem_width_e;

    // Routing tag, one per request in flight
    typedef enum logic {
        TGT_EXT   = 1'b0,
        TGT_TIMER = 1'b1
    } dmem_tgt_e;

    // --------------------
    // Transfer types
    // --------------------
    typedef struct packed {
        type_scr1_mem_cmd_e           cmd;
        type_scr1_mem_width_e         width;
        logic [SCR1_DMEM_AWIDTH-1:0]  addr;
        logic [SCR1_DMEM_DWIDTH-1:0]  wdata;
    } dmem_req_t;                               // 67 bits

    typedef struct packed {
        logic [SCR1_DMEM_DWIDTH-1:0]  rdata;
        logic                         err;
    } dmem_resp_t;                              // 33 bits

    // Timer register offsets within its 32-byte window
    localparam logic [4:0] SCR1_TIMER_CTRL        = 5'h00;  // Bit 0 is enable
    localparam logic [4:0] SCR1_TIMER_MTIME_LO    = 5'h08;
    localparam logic [4:0] SCR1_TIMER_MTIME_HI    = 5'h0C;
    localparam logic [4:0] SCR1_TIMER_MTIMECMP_LO = 5'h10;
    localparam logic [4:0] SCR1_TIMER_MTIMECMP_HI = 5'h14;

endpackage : scr1_mem_pkg

//--- hw/scr1_resp_merge.sv
// In-order response merge
// Circular queue of target tags and the response mux toward the core

`timescale 1ns/1ps

module scr1_resp_merge
    import scr1_mem_pkg::*;
#(
    parameter int ORDER_DEPTH = 4
) (
    input  logic        clk,
    input  logic        core_rst_n_local,

    // Tag push from dispatch
    input  logic        order_push_i,
    input  dmem_tgt_e   order_tgt_i,
    output logic        order_full_o,

    // Target responses
    input  logic        timer_resp_valid_i,
    input  dmem_resp_t  timer_resp_i,
    output logic        timer_resp_ready_o,
    input  logic        ext_resp_valid_i,
    input  dmem_resp_t  ext_resp_i,
    output logic        ext_resp_ready_o,

    // Core side
    output logic        core_resp_valid_o,
    output dmem_resp_t  core_resp_o,
    input  logic        core_resp_ready_i
);

    localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
    localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

    dmem_tgt_e               tag_q [ORDER_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [CNT_W-1:0]        count;
    logic                    empty;
    logic                    pop;
    dmem_tgt_e               head;

    assign empty        = (count == '0);
    assign order_full_o = (count == CNT_W'(ORDER_DEPTH));
    assign head         = tag_q[rd_ptr];

    // --------------------
    // Response mux
    // --------------------
    assign core_resp_valid_o  = ~empty & ((head == TGT_TIMER) ? timer_resp_valid_i
                                                              : ext_resp_valid_i);
    assign core_resp_o        = (head == TGT_TIMER) ? timer_resp_i : ext_resp_i;
    assign timer_resp_ready_o = ~empty & (head == TGT_TIMER) & core_resp_ready_i;
    assign ext_resp_ready_o   = ~empty & (head == TGT_EXT) & core_resp_ready_i;
    assign pop                = core_resp_valid_o & core_resp_ready_i;

    // --------------------
    // Tag queue
    // --------------------
    always_ff @(posedge clk) begin
        if (order_push_i) tag_q[wr_ptr] <= order_tgt_i;
    end

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (order_push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({order_push_i, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;              // Both or neither
            endcase
        end
    end

endmodule : scr1_resp_merge

//--- hw/scr1_timer.sv
// Memory-mapped machine timer
// Control, mtime and mtimecmp registers, compare interrupt, registered response

`timescale 1ns/1ps

module scr1_timer
    import scr1_mem_pkg::*;
(
    input  logic        clk,
    input  logic        core_rst_n_local,

    input  logic        req_valid_i,
    input  dmem_req_t   req_i,
    output logic        req_ready_o,

    output logic        resp_valid_o,
    output dmem_resp_t  resp_o,
    input  logic        resp_ready_i,

    output logic        timer_irq_o
);

    logic                         ctrl_en;
    logic [63:0]                  mtime;
    logic [63:0]                  mtimecmp;
    logic                         req_fire;
    logic                         wr_en;
    logic [4:0]                   req_offs;
    logic [SCR1_DMEM_DWIDTH-1:0]  rd_data;
    logic                         acc_err;

    assign req_ready_o = ~resp_valid_o | resp_ready_i;  // Empty or draining
    assign req_fire    = req_valid_i & req_ready_o;
    assign req_offs    = req_i.addr[4:0];
    assign wr_en       = req_fire & (req_i.cmd == SCR1_MEM_CMD_WR) & ~acc_err;

    // --------------------
    // Register decode
    // --------------------
    always_comb begin
        rd_data = '0;
        acc_err = 1'b0;
        case (req_offs)
            SCR1_TIMER_CTRL:        rd_data = {31'd0, ctrl_en};
            SCR1_TIMER_MTIME_LO:    rd_data = mtime[31:0];
            SCR1_TIMER_MTIME_HI:    rd_data = mtime[63:32];
            SCR1_TIMER_MTIMECMP_LO: rd_data = mtimecmp[31:0];
            SCR1_TIMER_MTIMECMP_HI: rd_data = mtimecmp[63:32];
            default:                acc_err = 1'b1;
        endcase
        if (req_i.width != SCR1_MEM_WIDTH_WORD) begin
            acc_err = 1'b1;         // Word access only
        end
    end

    // --------------------
    // Timer registers
    // --------------------
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            ctrl_en  <= 1'b0;
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            if (ctrl_en) mtime <= mtime + 64'd1;
            if (wr_en) begin
                case (req_offs)     // A write wins over the count for its half
                    SCR1_TIMER_CTRL:        ctrl_en         <= req_i.wdata[0];
                    SCR1_TIMER_MTIME_LO:    mtime[31:0]     <= req_i.wdata;
                    SCR1_TIMER_MTIME_HI:    mtime[63:32]    <= req_i.wdata;
                    SCR1_TIMER_MTIMECMP_LO: mtimecmp[31:0]  <= req_i.wdata;
                    SCR1_TIMER_MTIMECMP_HI: mtimecmp[63:32] <= req_i.wdata;
                    default:                ;
                endcase
            end
        end
    end

    // Response register
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_valid_o <= 1'b0;
        end else if (req_fire) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            resp_o.rdata <= rd_data;
            resp_o.err   <= acc_err;
        end
    end

    assign timer_irq_o = ctrl_en & (mtime >= mtimecmp);

endmodule : scr1_timer

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_mem_cluster -o tb_mem_cluster

out="$(./obj_dir/tb_mem_cluster)"
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- testbench/tb_mem_cluster.sv
// Testbench for the data memory cluster
// Clock and reset, external memory model, response scoreboard and assertions
// Directed timer and external memory tests, then random interleaved traffic

`timescale 1ns/1ps

module tb_mem_cluster
    import scr1_mem_pkg::*;
();

    localparam int          RST_CYCLES = 5;
    localparam int          N_REQ      = 69;
    localparam int          TIMEOUT    = N_REQ * 20 + 500;
    localparam logic [31:0] TIMER_BASE = 32'h0049_0000;
    localparam logic [31:0] EXT_BASE   = 32'h0000_1000;

    typedef struct packed {
        logic       chk_data;           // Data compared only when set
        dmem_resp_t resp;
    } exp_t;

    logic        clk = 1'b0;
    logic        core_rst_n_local = 1'b0;
    logic        core_req_valid_i = 1'b0;
    dmem_req_t   core_req_i = '0;
    logic        core_req_ready_o;
    logic        core_resp_valid_o;
    dmem_resp_t  core_resp_o;
    logic        core_resp_ready_i = 1'b0;
    logic        ext_req_valid_o;
    dmem_req_t   ext_req_o;
    logic        ext_req_ready_i = 1'b0;
    logic        ext_resp_valid_i = 1'b0;
    dmem_resp_t  ext_resp_i = '0;
    logic        ext_resp_ready_o;
    logic        timer_irq_o;

    integer      seed = 58987;
    int          cycle = 0;
    int          val_errs = 0;
    int          other_errs = 0;
    exp_t        exp_q[$];
    exp_t        exp_head = '0;
    exp_t        drv_exp = '0;
    logic        exp_avail = 1'b0;
    logic [31:0] last_rdata;
    logic        irq_off_chk = 1'b0;
    logic [31:0] ref_mem [64];
    logic [31:0] ext_mem [64];
    dmem_resp_t  pend_q[$];
    dmem_resp_t  mdl_resp;
    int          resp_gap = 0;

    always #50 clk = ~clk;

    scr1_mem_cluster #(
        .TIMER_ADDR_MASK    (32'hFFFF_FFE0),
        .TIMER_ADDR_PATTERN (TIMER_BASE),
        .ORDER_DEPTH        (4)
    ) dut (
        .clk               (clk),
        .core_rst_n_local  (core_rst_n_local),
        .core_req_valid_i  (core_req_valid_i),
        .core_req_i        (core_req_i),
        .core_req_ready_o  (core_req_ready_o),
        .core_resp_valid_o (core_resp_valid_o),
        .core_resp_o       (core_resp_o),
        .core_resp_ready_i (core_resp_ready_i),
        .ext_req_valid_o   (ext_req_valid_o),
        .ext_req_o         (ext_req_o),
        .ext_req_ready_i   (ext_req_ready_i),
        .ext_resp_valid_i  (ext_resp_valid_i),
        .ext_resp_i        (ext_resp_i),
        .ext_resp_ready_o  (ext_resp_ready_o),
        .timer_irq_o       (timer_irq_o)
    );

    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        logic [31:0] addr;
        addr = EXT_BASE + {24'd0, idx, 2'b00};
        return {addr[15:0] ^ 16'h5A3C, addr[15:0]};
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
        val_errs++;
    endtask

    task automatic print_counts();
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
    endtask

    // --------------------
    // Core request driver
    // --------------------
    task automatic send_req(input type_scr1_mem_cmd_e cmd, input type_scr1_mem_width_e width,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic chk, input logic [31:0] rdata, input logic err);
        exp_t      e;
        dmem_req_t r;
        e.chk_data   = chk;
        e.resp.rdata = rdata;
        e.resp.err   = err;
        r.cmd        = cmd;
        r.width      = width;
        r.addr       = addr;
        r.wdata      = wdata;
        core_req_valid_i <= 1'b1;
        core_req_i       <= r;
        drv_exp          <= e;
        do @(posedge clk); while (!core_req_ready_o);  // Held until accepted
    endtask

    task automatic ext_write(input logic [5:0] idx, input logic [31:0] data);
        ref_mem[idx] = data;
        send_req(SCR1_MEM_CMD_WR, SCR1_MEM_WIDTH_WORD, EXT_BASE + {24'd0, idx, 2'b00},
                 data, 1'b0, '0, 1'b0);
    endtask

    task automatic ext_read(input logic [5:0] idx);
        send_req(SCR1_MEM_CMD_RD, SCR1_MEM_WIDTH_WORD, EXT_BASE + {24'd0, idx, 2'b00},
                 '0, 1'b1, ref_mem[idx], 1'b0);
    endtask

    task automatic timer_write(input logic [4:0] offs, input logic [31:0] data);
        send_req(SCR1_MEM_CMD_WR, SCR1_MEM_WIDTH_WORD, {TIMER_BASE[31:5], offs},
                 data, 1'b0, '0, 1'b0);
    endtask

    task automatic timer_read(input logic [4:0] offs, input logic chk, input logic [31:0] data);
        send_req(SCR1_MEM_CMD_RD, SCR1_MEM_WIDTH_WORD, {TIMER_BASE[31:5], offs},
                 '0, chk, data, 1'b0);
    endtask

    // Queue state is looked at mid-cycle, away from the edge that updates it
    task automatic drain();
        core_req_valid_i <= 1'b0;
        do @(negedge clk); while (exp_q.size() != 0);
        @(posedge clk);
    endtask

    // --------------------
    // External memory model
    // --------------------
    always @(posedge clk) begin
        if (!core_rst_n_local) begin
            ext_req_ready_i  <= 1'b0;
            ext_resp_valid_i <= 1'b0;
            resp_gap = 0;
            pend_q.delete();
            for (int i = 0; i < 64; i++) ext_mem[6'(i)] = fill_word(6'(i));
        end else begin
            if (ext_req_valid_o && ext_req_ready_i) begin
                mdl_resp.err   = 1'b0;
                mdl_resp.rdata = ext_mem[ext_req_o.addr[7:2]];
                if (ext_req_o.cmd == SCR1_MEM_CMD_WR) begin
                    ext_mem[ext_req_o.addr[7:2]] = ext_req_o.wdata;
                end
                pend_q.push_back(mdl_resp);
            end
            if (!ext_resp_valid_i || ext_resp_ready_o) begin
                if (pend_q.size() > 0 && resp_gap == 0) begin
                    ext_resp_valid_i <= 1'b1;
                    ext_resp_i       <= pend_q.pop_front();
                    resp_gap = $unsigned($random(seed)) % 4;    // Gap before the next one
                end else begin
                    ext_resp_valid_i <= 1'b0;
                    if (resp_gap > 0) resp_gap = resp_gap - 1;
                end
            end
            ext_req_ready_i <= ($unsigned($random(seed)) % 4) != 0;
        end
    end

    // Random core back-pressure
    always @(posedge clk) begin
        if (!core_rst_n_local) core_resp_ready_i <= 1'b0;
        else core_resp_ready_i <= ($unsigned($random(seed)) % 3) != 0;
    end

    // --------------------
    // Scoreboard
    // --------------------
    always @(posedge clk) begin
        if (!core_rst_n_local) begin
            exp_q.delete();
        end else begin
            if (core_resp_valid_o && core_resp_ready_i) begin
                last_rdata = core_resp_o.rdata;
                if (exp_q.size() > 0) void'(exp_q.pop_front());
            end
            if (core_req_valid_i && core_req_ready_o) exp_q.push_back(drv_exp);
        end
        exp_avail = (exp_q.size() > 0);
        exp_head  = exp_avail ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout after %0d cycles with %0d responses missing", cycle, exp_q.size());
            print_counts();
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------
    // Assertions
    // --------------------
    rst_idle_chk: assert property (@(posedge clk) (cycle >= 1 && cycle <= RST_CYCLES)
            |-> !core_resp_valid_o && !ext_req_valid_o && !timer_irq_o)
        else begin
            $display("outputs not idle at %0t around reset", $time);
            other_errs++;
        end

    resp_expected_chk: assert property (@(posedge clk) disable iff (!core_rst_n_local)
            core_resp_valid_o && core_resp_ready_i |-> exp_avail)
        else begin
            $display("response at %0t with no request outstanding", $time);
            other_errs++;
        end

    resp_err_chk: assert property (@(posedge clk) disable iff (!core_rst_n_local)
            core_resp_valid_o && core_resp_ready_i && exp_avail
            |-> core_resp_o.err == exp_head.resp.err)
        else report_value("core_resp_o.err", 32'($sampled(exp_head.resp.err)),
                          32'($sampled(core_resp_o.err)));

    resp_data_chk: assert property (@(posedge clk) disable iff (!core_rst_n_local)
            core_resp_valid_o && core_resp_ready_i && exp_avail && exp_head.chk_data
            |-> core_resp_o.rdata == exp_head.resp.rdata)
        else report_value("core_resp_o.rdata", $sampled(exp_head.resp.rdata),
                          $sampled(core_resp_o.rdata));

    resp_hold_chk: assert property (@(posedge clk) disable iff (!core_rst_n_local)
            core_resp_valid_o && !core_resp_ready_i
            |=> core_resp_valid_o && core_resp_o == $past(core_resp_o))
        else begin
            $display("core response dropped or changed at %0t while stalled", $time);
            other_errs++;
        end

    irq_off_chk_a: assert property (@(posedge clk) disable iff (!core_rst_n_local)
            irq_off_chk |-> !timer_irq_o)
        else begin
            $display("timer_irq_o high at %0t with mtimecmp at all ones", $time);
            other_errs++;
        end

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [31:0] t0;
        logic [31:0] t1;
        logic [5:0]  idx;
        int          wait_cnt;
        int          pick;

        for (int i = 0; i < 64; i++) ref_mem[6'(i)] = fill_word(6'(i));
        repeat (RST_CYCLES) @(posedge clk);
        core_rst_n_local <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < 16; i++) ext_write(6'(i), $random(seed));
        for (int i = 0; i < 16; i++) ext_read(6'(i));
        drain();

        // Timer registers
        timer_write(SCR1_TIMER_MTIMECMP_LO, 32'h1234_5678);
        timer_write(SCR1_TIMER_MTIMECMP_HI, 32'h0000_ABCD);
        timer_read(SCR1_TIMER_MTIMECMP_LO, 1'b1, 32'h1234_5678);
        timer_read(SCR1_TIMER_MTIMECMP_HI, 1'b1, 32'h0000_ABCD);
        timer_write(SCR1_TIMER_CTRL, 32'h1);
        timer_read(SCR1_TIMER_MTIME_LO, 1'b0, '0);
        drain();
        t0 = last_rdata;
        timer_read(SCR1_TIMER_MTIME_LO, 1'b0, '0);
        drain();
        t1 = last_rdata;
        assert (t1 > t0) else begin
            $display("error at %0t: mtime_lo expected above %h actual %h", $time, t0, t1);
            val_errs++;
        end

        // Interrupt on a small compare value, then off again
        timer_write(SCR1_TIMER_MTIMECMP_LO, 32'd256);
        timer_write(SCR1_TIMER_MTIMECMP_HI, 32'd0);
        drain();
        wait_cnt = 0;
        while (!timer_irq_o && wait_cnt < 400) begin
            @(posedge clk);
            wait_cnt++;
        end
        assert (timer_irq_o) else begin
            $display("timer_irq_o did not rise once mtime reached mtimecmp");
            other_errs++;
        end
        timer_write(SCR1_TIMER_MTIMECMP_HI, 32'hFFFF_FFFF);
        timer_write(SCR1_TIMER_MTIMECMP_LO, 32'hFFFF_FFFF);
        drain();
        irq_off_chk <= 1'b1;

        // Bad width and unmapped offset
        send_req(SCR1_MEM_CMD_RD, SCR1_MEM_WIDTH_BYTE, {TIMER_BASE[31:5], SCR1_TIMER_CTRL},
                 '0, 1'b0, '0, 1'b1);
        send_req(SCR1_MEM_CMD_RD, SCR1_MEM_WIDTH_WORD, {TIMER_BASE[31:5], 5'h04},
                 '0, 1'b0, '0, 1'b1);
        drain();

        // Random mix across both targets
        for (int i = 0; i < 24; i++) begin
            pick = $unsigned($random(seed)) % 3;
            idx  = 6'($unsigned($random(seed)));
            if (pick == 0) timer_read(SCR1_TIMER_MTIMECMP_LO, 1'b1, 32'hFFFF_FFFF);
            else if (pick == 1) ext_read(idx);
            else ext_write(idx, $random(seed));
        end
        drain();

        repeat (4) @(posedge clk);
        print_counts();
        if (val_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : tb_mem_cluster
